// File: Bender.yml
package:
  name: axi_wb_core

export_include_dirs:
  - src

sources:
  - include_dirs:
      - src
    files:
      - src/axi_wb_pkg.sv
      - src/wb_front.sv
      - src/axi_wr_engine.sv
      - src/axi_rd_engine.sv
      - src/axi_wb_core.sv
  - target: simulation
    include_dirs:
      - src
    files:
      - sim/tb_clkgen.sv
      - sim/tb_axi_wb_core.sv

// File: axi_wb_core.f
+incdir+src
src/axi_wb_pkg.sv
src/wb_front.sv
src/axi_wr_engine.sv
src/axi_rd_engine.sv
src/axi_wb_core.sv
sim/tb_clkgen.sv
sim/tb_axi_wb_core.sv

// File: sim/tb_axi_wb_core.sv
`include "axi_wb_macros.svh"

module tb_axi_wb_core
    import axi_wb_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int   NUM_STEPS   = 16;
    localparam int   ACK_TIMEOUT = 200;
    localparam int   POOL_SIZE   = 256;
    localparam logic WR          = 1'b1;
    localparam logic RD          = 1'b0;
    localparam logic AW_1ST      = 1'b1;
    localparam logic W_1ST       = 1'b0;

    typedef struct packed {
        logic                  we;
        logic [`AXI_WB_WA-1:0] adr;
        logic [`AXI_WB_DW-1:0] dat;
        logic [`AXI_WB_SW-1:0] sel;
        axi_resp_e             resp;
        logic                  aw_first;                         // Model takes AW before W
        logic [`AXI_WB_DW-1:0] exp;                              // Expected o_wb_rdt
    } step_t;

    logic                  clk;
    logic                  i_rst_n;
    logic                  i_wb_stb   = 1'b0;
    wb_req_t               i_wb_req   = '0;
    logic [`AXI_WB_DW-1:0] o_wb_rdt;
    logic                  o_wb_ack;
    logic [`AXI_WB_AW-1:0] o_awmaddr;
    logic                  o_awmvalid;
    logic                  i_awmready = 1'b0;
    logic [`AXI_WB_AW-1:0] o_armaddr;
    logic                  o_armvalid;
    logic                  i_armready = 1'b0;
    logic [`AXI_WB_DW-1:0] o_wmdata;
    logic [`AXI_WB_SW-1:0] o_wmstrb;
    logic                  o_wmvalid;
    logic                  i_wmready  = 1'b0;
    logic [1:0]            i_bmresp   = 2'b00;
    logic                  i_bmvalid  = 1'b0;
    logic                  o_bmready;
    logic [`AXI_WB_DW-1:0] i_rmdata   = '0;
    logic [1:0]            i_rmresp   = 2'b00;
    logic                  i_rmlast   = 1'b1;                    // Every beat is the last
    logic                  i_rmvalid  = 1'b0;
    logic                  o_rmready;

    logic [`AXI_WB_DW-1:0] mem [64];
    int                    delay_pool [POOL_SIZE];
    int                    pool_idx    = 0;
    step_t                 steps [NUM_STEPS];
    step_t                 cur         = '0;
    logic                  got_aw      = 1'b0;
    logic                  got_w       = 1'b0;
    logic                  got_ar      = 1'b0;
    logic [`AXI_WB_AW-1:0] aw_addr_q;
    logic [`AXI_WB_AW-1:0] ar_addr_q;
    logic [`AXI_WB_DW-1:0] w_data_q;
    logic [`AXI_WB_SW-1:0] w_strb_q;
    int                    dly_addr    = 0;
    int                    dly_w       = 0;
    int                    dly_rsp     = 0;
    logic                  awvalid_d   = 1'b0;
    logic                  arvalid_d   = 1'b0;
    int                    ack_count   = 0;
    int                    start_count = 0;
    int                    errors      = 0;

    tb_clkgen u_clkgen (.o_clk(clk), .o_rst_n(i_rst_n));

    axi_wb_core DUT (.*);

    task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
        assert (got === exp) else begin
            $display("ERR %s got %h exp %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_idle();
        check_value("o_wb_ack", 32'(o_wb_ack), 32'h0);
        check_value("o_awmvalid", 32'(o_awmvalid), 32'h0);
        check_value("o_wmvalid", 32'(o_wmvalid), 32'h0);
        check_value("o_armvalid", 32'(o_armvalid), 32'h0);
        check_value("o_bmready", 32'(o_bmready), 32'h0);
        check_value("o_rmready", 32'(o_rmready), 32'h0);
    endtask

    function automatic int next_delay();
        next_delay = delay_pool[pool_idx];
        pool_idx   = (pool_idx + 1) % POOL_SIZE;
    endfunction

    function automatic step_t make_step(logic we, int adr, logic [`AXI_WB_DW-1:0] dat,
                                        logic [`AXI_WB_SW-1:0] sel, axi_resp_e resp,
                                        logic aw_first, logic [`AXI_WB_DW-1:0] exp);
        step_t s;
        s.we       = we;
        s.adr      = adr[`AXI_WB_WA-1:0];
        s.dat      = dat;
        s.sel      = sel;
        s.resp     = resp;
        s.aw_first = aw_first;
        s.exp      = exp;
        return s;
    endfunction

    ////////////////////
    // AXI slave model
    ////////////////////
    always @(posedge clk) begin
        if (i_rst_n) begin
            if (o_awmvalid && i_awmready) begin
                i_awmready <= 1'b0;
                got_aw     <= 1'b1;
                aw_addr_q  <= o_awmaddr;
                check_value("o_awmaddr", 32'(o_awmaddr), 32'(cur.adr) * 4);
            end else if (o_awmvalid && (cur.aw_first || got_w)) begin
                if (dly_addr == 0) begin
                    i_awmready <= 1'b1;
                    dly_addr   <= next_delay();
                end else begin
                    dly_addr <= dly_addr - 1;
                end
            end

            if (o_wmvalid && i_wmready) begin
                i_wmready <= 1'b0;
                got_w     <= 1'b1;
                w_data_q  <= o_wmdata;
                w_strb_q  <= o_wmstrb;
                check_value("o_wmdata", o_wmdata, cur.dat);
                check_value("o_wmstrb", 32'(o_wmstrb), 32'(cur.sel));
            end else if (o_wmvalid && (!cur.aw_first || got_aw)) begin
                if (dly_w == 0) begin
                    i_wmready <= 1'b1;
                    dly_w     <= next_delay();
                end else begin
                    dly_w <= dly_w - 1;
                end
            end

            if (i_bmvalid && o_bmready) begin
                i_bmvalid <= 1'b0;
                got_aw    <= 1'b0;
                got_w     <= 1'b0;
            end else if (got_aw && got_w && !i_bmvalid) begin
                if (dly_rsp == 0) begin
                    i_bmvalid <= 1'b1;
                    i_bmresp  <= cur.resp;
                    dly_rsp   <= next_delay();
                    if (cur.resp == RESP_OKAY) begin                 // Failed writes leave memory
                        for (int b = 0; b < `AXI_WB_SW; b++) begin
                            if (w_strb_q[b]) mem[aw_addr_q[7:2]][8*b +: 8] = w_data_q[8*b +: 8];
                        end
                    end
                end else begin
                    dly_rsp <= dly_rsp - 1;
                end
            end

            if (o_armvalid && i_armready) begin
                i_armready <= 1'b0;
                got_ar     <= 1'b1;
                ar_addr_q  <= o_armaddr;
                check_value("o_armaddr", 32'(o_armaddr), 32'(cur.adr) * 4);
            end else if (o_armvalid) begin
                if (dly_addr == 0) begin
                    i_armready <= 1'b1;
                    dly_addr   <= next_delay();
                end else begin
                    dly_addr <= dly_addr - 1;
                end
            end

            if (i_rmvalid && o_rmready) begin
                i_rmvalid <= 1'b0;
                got_ar    <= 1'b0;
            end else if (got_ar && !i_rmvalid) begin
                if (dly_rsp == 0) begin
                    i_rmvalid <= 1'b1;
                    i_rmdata  <= mem[ar_addr_q[7:2]];                // Real data even on errors
                    i_rmresp  <= cur.resp;
                    dly_rsp   <= next_delay();
                end else begin
                    dly_rsp <= dly_rsp - 1;
                end
            end
        end
    end

    // Request starts and acknowledges
    always @(posedge clk) begin
        awvalid_d   <= o_awmvalid;
        arvalid_d   <= o_armvalid;
        start_count <= start_count + int'(o_awmvalid && !awvalid_d)
                                   + int'(o_armvalid && !arvalid_d);
        if (o_wb_ack) begin
            ack_count <= ack_count + 1;
        end
    end

    ////////////////////
    // Stimulus
    ////////////////////
    initial begin
        int                    n;
        int                    r;
        int                    rows_failed;
        int                    err_before;
        int                    acks_before;
        int                    starts_before;
        logic                  seen;
        logic                  timed_out;
        logic [`AXI_WB_DW-1:0] rdt;

        n = $urandom(32'hd5df_7afe);
        for (n = 0; n < POOL_SIZE; n++) begin
            delay_pool[n] = $urandom % 8;                        // 0 to 7 cycles
        end
        for (n = 0; n < 64; n++) begin
            mem[n] = {8'ha0 + 8'(n), 8'hb0 + 8'(n), 8'hc0 + 8'(n), 8'hd0 + 8'(n)};
        end

        // op, word, data, sel, response, order, expected o_wb_rdt
        steps[0]  = make_step(RD, 5,  32'h0,         4'h0, RESP_OKAY,   AW_1ST, 32'ha5b5_c5d5);
        steps[1]  = make_step(WR, 5,  32'h1122_3344, 4'hf, RESP_OKAY,   AW_1ST, 32'h0);
        steps[2]  = make_step(RD, 5,  32'h0,         4'h0, RESP_OKAY,   AW_1ST, 32'h1122_3344);
        steps[3]  = make_step(WR, 9,  32'hdead_beef, 4'h5, RESP_OKAY,   W_1ST,  32'h0);
        steps[4]  = make_step(RD, 9,  32'h0,         4'h0, RESP_OKAY,   AW_1ST, 32'ha9ad_c9ef);
        steps[5]  = make_step(WR, 12, 32'hcafe_0000, 4'hc, RESP_OKAY,   W_1ST,  32'h0);
        steps[6]  = make_step(RD, 12, 32'h0,         4'h0, RESP_OKAY,   AW_1ST, 32'hcafe_ccdc);
        steps[7]  = make_step(RD, 12, 32'h0,         4'h0, RESP_SLVERR, AW_1ST, 32'h0);
        steps[8]  = make_step(RD, 5,  32'h0,         4'h0, RESP_DECERR, AW_1ST, 32'h0);
        steps[9]  = make_step(WR, 20, 32'h5555_5555, 4'hf, RESP_SLVERR, AW_1ST, 32'h0);
        steps[10] = make_step(RD, 20, 32'h0,         4'h0, RESP_OKAY,   AW_1ST, 32'hb4c4_d4e4);
        steps[11] = make_step(RD, 9,  32'h0,         4'h0, RESP_EXOKAY, AW_1ST, 32'ha9ad_c9ef);
        steps[12] = make_step(WR, 63, 32'h0bad_f00d, 4'h8, RESP_OKAY,   W_1ST,  32'h0);
        steps[13] = make_step(RD, 63, 32'h0,         4'h0, RESP_OKAY,   AW_1ST, 32'h0bef_ff0f);
        steps[14] = make_step(WR, 40, 32'h1234_5678, 4'h6, RESP_OKAY,   AW_1ST, 32'h0);
        steps[15] = make_step(RD, 40, 32'h0,         4'h0, RESP_OKAY,   AW_1ST, 32'hc834_56f8);

        timed_out   = 1'b0;
        rows_failed = 0;
        n           = 0;
        while (i_rst_n !== 1'b1 && n < 20) begin
            @(posedge clk);
            n++;
        end
        if (i_rst_n !== 1'b1) begin
            timed_out = 1'b1;
            $display("Reset was never released");
        end
        repeat (4) begin                                         // Quiet before the first strobe
            @(posedge clk);
            check_idle();
        end

        for (r = 0; r < NUM_STEPS && !timed_out; r++) begin
            cur           = steps[r];
            err_before    = errors;
            acks_before   = ack_count;
            starts_before = start_count;
            @(posedge clk);
            i_wb_req <= '{adr: cur.adr, dat: cur.dat, sel: cur.sel, we: cur.we};
            i_wb_stb <= 1'b1;
            seen = 1'b0;
            n    = 0;
            while (!seen && n < ACK_TIMEOUT) begin
                @(posedge clk);
                n++;
                if (o_wb_ack) begin
                    seen = 1'b1;
                    rdt  = o_wb_rdt;
                end
            end
            i_wb_stb <= 1'b0;
            if (!seen) begin
                timed_out = 1'b1;
                $display("Row %0d: no o_wb_ack within %0d cycles", r, ACK_TIMEOUT);
            end else begin
                check_value("o_wb_rdt", rdt, cur.exp);
                repeat (3) @(posedge clk);                       // Hold and return to idle
                assert (ack_count - acks_before == 1) else begin
                    $display("Row %0d: %0d acknowledges for one request", r,
                             ack_count - acks_before);
                    errors++;
                end
                assert (start_count - starts_before == 1) else begin
                    $display("Row %0d: %0d AXI requests for one request", r,
                             start_count - starts_before);
                    errors++;
                end
                check_idle();
            end
            if (errors != err_before || !seen) begin
                rows_failed++;
            end
            $display("Row %2d %s word %03h: %s", r, cur.we ? "write" : "read ", cur.adr,
                     (errors == err_before && seen) ? "pass" : "fail");
        end

        $display("Rows %0d, failed %0d, errors %0d", r, rows_failed, errors);
        if (timed_out || errors != 0 || rows_failed != 0) begin
            $display("TEST FAILED");
        end else begin
            $display("TEST OK");
        end
        $finish;
    end

endmodule

// File: sim/tb_clkgen.sv
module tb_clkgen (
    output logic o_clk,
    output logic o_rst_n
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int HALF_PERIOD  = 20;
    localparam int RESET_CYCLES = 10;

    initial begin
        o_clk = 1'b0;
        forever #(HALF_PERIOD) o_clk = ~o_clk;                   // 40 ns period
    end

    initial begin
        o_rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge o_clk);
        o_rst_n <= 1'b1;                                         // Released on an edge
    end

endmodule

// File: src/axi_rd_engine.sv
`include "axi_wb_macros.svh"

module axi_rd_engine
    import axi_wb_pkg::*;
(
    input  logic                  clk,
    input  logic                  i_rst_n,
    input  logic                  i_start,
    input  wb_req_t               i_req,

    // AR channel
    output logic [`AXI_WB_AW-1:0] o_armaddr,
    output logic                  o_armvalid,
    input  logic                  i_armready,

    // R channel
    input  logic [`AXI_WB_DW-1:0] i_rmdata,
    input  logic [1:0]            i_rmresp,
    input  logic                  i_rmlast,                      // Single beat, always last
    input  logic                  i_rmvalid,
    output logic                  o_rmready,

    output logic                  o_done,
    output rd_rsp_t               o_rsp
);

    rd_state_e state;
    axi_resp_e resp;
    logic      resp_ok;

    assign resp    = axi_resp_e'(i_rmresp);
    assign resp_ok = (resp == RESP_OKAY) || (resp == RESP_EXOKAY);

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state      <= R_IDLE;
            o_armvalid <= 1'b0;
            o_rmready  <= 1'b0;
        end else begin
            case (state)
                R_IDLE: if (i_start) begin
                    o_armvalid <= 1'b1;
                    state      <= R_ADDR;
                end
                R_ADDR: if (i_armready) begin
                    o_armvalid <= 1'b0;
                    o_rmready  <= 1'b1;                          // Ready only after AR
                    state      <= R_DATA;
                end
                R_DATA: if (i_rmvalid) begin
                    o_rmready <= 1'b0;
                    state     <= R_DONE;
                end
                R_DONE:  state <= R_IDLE;
                default: state <= R_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == R_IDLE && i_start) begin
            o_armaddr <= {i_req.adr, 2'b00};
        end
        if (state == R_DATA && i_rmvalid) begin
            o_rsp.data <= resp_ok ? i_rmdata : '0;               // Errors read as zero
            o_rsp.resp <= resp;
        end
    end

    assign o_done = (state == R_DONE);

endmodule

// File: src/axi_wb_core.sv
`include "axi_wb_macros.svh"

module axi_wb_core
    import axi_wb_pkg::*;
(
    input  logic                  clk,
    input  logic                  i_rst_n,

    // Wishbone slave
    input  logic                  i_wb_stb,
    input  wb_req_t               i_wb_req,
    output logic [`AXI_WB_DW-1:0] o_wb_rdt,
    output logic                  o_wb_ack,

    // AXI master
    output logic [`AXI_WB_AW-1:0] o_awmaddr,
    output logic                  o_awmvalid,
    input  logic                  i_awmready,
    output logic [`AXI_WB_AW-1:0] o_armaddr,
    output logic                  o_armvalid,
    input  logic                  i_armready,
    output logic [`AXI_WB_DW-1:0] o_wmdata,
    output logic [`AXI_WB_SW-1:0] o_wmstrb,
    output logic                  o_wmvalid,
    input  logic                  i_wmready,
    input  logic [1:0]            i_bmresp,
    input  logic                  i_bmvalid,
    output logic                  o_bmready,
    input  logic [`AXI_WB_DW-1:0] i_rmdata,
    input  logic [1:0]            i_rmresp,
    input  logic                  i_rmlast,
    input  logic                  i_rmvalid,
    output logic                  o_rmready
);

    wb_req_t req;
    logic    wr_start;
    logic    rd_start;
    logic    wr_done;
    logic    rd_done;
    rd_rsp_t rd_rsp;

    wb_front u_front (
        .clk, .i_rst_n, .i_wb_stb, .i_wb_req, .o_wb_rdt, .o_wb_ack,
        .o_req(req), .o_wr_start(wr_start), .o_rd_start(rd_start),
        .i_wr_done(wr_done), .i_rd_done(rd_done), .i_rd_rsp(rd_rsp)
    );

    axi_wr_engine u_wr (
        .clk, .i_rst_n, .i_start(wr_start), .i_req(req),
        .o_awmaddr, .o_awmvalid, .i_awmready,
        .o_wmdata, .o_wmstrb, .o_wmvalid, .i_wmready,
        .i_bmresp, .i_bmvalid, .o_bmready,
        .o_done(wr_done)
    );

    axi_rd_engine u_rd (
        .clk, .i_rst_n, .i_start(rd_start), .i_req(req),
        .o_armaddr, .o_armvalid, .i_armready,
        .i_rmdata, .i_rmresp, .i_rmlast, .i_rmvalid, .o_rmready,
        .o_done(rd_done), .o_rsp(rd_rsp)
    );

endmodule

// File: src/axi_wb_macros.svh
`ifndef AXI_WB_MACROS_SVH
`define AXI_WB_MACROS_SVH

////////////////////
// Bus widths
////////////////////

// Byte address width seen on the AXI side
`define AXI_WB_AW 13

// Data width of both buses
`define AXI_WB_DW 32

// Byte lanes per data word
`define AXI_WB_SW (`AXI_WB_DW / 8)

// Word address width seen on the Wishbone side
`define AXI_WB_WA (`AXI_WB_AW - 2)

`endif

// File: src/axi_wb_pkg.sv
`include "axi_wb_macros.svh"

package axi_wb_pkg;

    ////////////////////
    // AXI response codes
    ////////////////////
    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_EXOKAY = 2'b01,
        RESP_SLVERR = 2'b10,
        RESP_DECERR = 2'b11
    } axi_resp_e;

    ////////////////////
    // Request and response
    ////////////////////
    typedef struct packed {
        logic [`AXI_WB_WA-1:0] adr;     // Word address
        logic [`AXI_WB_DW-1:0] dat;
        logic [`AXI_WB_SW-1:0] sel;     // Byte lane enables
        logic                  we;
    } wb_req_t;

    typedef struct packed {
        logic [`AXI_WB_DW-1:0] data;
        axi_resp_e             resp;
    } rd_rsp_t;

    ////////////////////
    // State machines
    ////////////////////
    typedef enum logic [2:0] {
        F_IDLE, F_CAPTURE, F_BUSY, F_ACK, F_HOLD
    } front_state_e;

    typedef enum logic [1:0] {
        W_IDLE, W_ADDR, W_RESP, W_DONE
    } wr_state_e;

    typedef enum logic [1:0] {
        R_IDLE, R_ADDR, R_DATA, R_DONE
    } rd_state_e;

endpackage

// File: src/axi_wr_engine.sv
`include "axi_wb_macros.svh"

module axi_wr_engine
    import axi_wb_pkg::*;
(
    input  logic                  clk,
    input  logic                  i_rst_n,
    input  logic                  i_start,
    input  wb_req_t               i_req,

    // AW channel
    output logic [`AXI_WB_AW-1:0] o_awmaddr,
    output logic                  o_awmvalid,
    input  logic                  i_awmready,

    // W channel
    output logic [`AXI_WB_DW-1:0] o_wmdata,
    output logic [`AXI_WB_SW-1:0] o_wmstrb,
    output logic                  o_wmvalid,
    input  logic                  i_wmready,

    // B channel
    input  logic [1:0]            i_bmresp,
    input  logic                  i_bmvalid,
    output logic                  o_bmready,

    output logic                  o_done
);

    wr_state_e state;
    logic      aw_ok;                                            // AW already accepted
    logic      w_ok;                                             // W already accepted
    logic      aw_hs;
    logic      w_hs;

    assign aw_hs = o_awmvalid && i_awmready;
    assign w_hs  = o_wmvalid && i_wmready;

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state      <= W_IDLE;
            aw_ok      <= 1'b0;
            w_ok       <= 1'b0;
            o_awmvalid <= 1'b0;
            o_wmvalid  <= 1'b0;
            o_bmready  <= 1'b0;
        end else begin
            case (state)
                W_IDLE: if (i_start) begin
                    aw_ok      <= 1'b0;
                    w_ok       <= 1'b0;
                    o_awmvalid <= 1'b1;                          // AW and W raised together
                    o_wmvalid  <= 1'b1;
                    state      <= W_ADDR;
                end
                W_ADDR: begin
                    if (aw_hs) begin
                        o_awmvalid <= 1'b0;
                        aw_ok      <= 1'b1;
                    end
                    if (w_hs) begin
                        o_wmvalid <= 1'b0;
                        w_ok      <= 1'b1;
                    end
                    if ((aw_ok || aw_hs) && (w_ok || w_hs)) begin
                        o_bmready <= 1'b1;
                        state     <= W_RESP;
                    end
                end
                W_RESP: if (i_bmvalid && o_bmready) begin
                    o_bmready <= 1'b0;                           // Response dropped
                    state     <= W_DONE;
                end
                W_DONE:  state <= W_IDLE;
                default: state <= W_IDLE;
            endcase
        end
    end

    // Payload held for the whole write
    always_ff @(posedge clk) begin
        if (state == W_IDLE && i_start) begin
            o_awmaddr <= {i_req.adr, 2'b00};
            o_wmdata  <= i_req.dat;
            o_wmstrb  <= i_req.sel;
        end
    end

    assign o_done = (state == W_DONE);

endmodule

// File: src/wb_front.sv
`include "axi_wb_macros.svh"

module wb_front
    import axi_wb_pkg::*;
(
    input  logic                  clk,
    input  logic                  i_rst_n,

    // Wishbone slave
    input  logic                  i_wb_stb,
    input  wb_req_t               i_wb_req,
    output logic [`AXI_WB_DW-1:0] o_wb_rdt,
    output logic                  o_wb_ack,

    // Engine control
    output wb_req_t               o_req,
    output logic                  o_wr_start,
    output logic                  o_rd_start,
    input  logic                  i_wr_done,
    input  logic                  i_rd_done,
    input  rd_rsp_t               i_rd_rsp
);

    front_state_e          state;
    wb_req_t               req_q;
    logic [`AXI_WB_DW-1:0] rdt_q;

    ////////////////////
    // Control FSM
    ////////////////////
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state <= F_IDLE;
        end else begin
            case (state)
                F_IDLE:    if (i_wb_stb) state <= F_CAPTURE;
                F_CAPTURE: state <= F_BUSY;                      // Start pulse goes out here
                F_BUSY:    if (i_wr_done || i_rd_done) state <= F_ACK;
                F_ACK:     state <= F_HOLD;
                F_HOLD:    state <= F_IDLE;                      // Master drops stb here
                default:   state <= F_IDLE;
            endcase
        end
    end

    ////////////////////
    // Request and read data
    ////////////////////
    always_ff @(posedge clk) begin
        if (state == F_IDLE && i_wb_stb) begin
            req_q <= i_wb_req;
        end
        if (state == F_BUSY) begin
            if (i_rd_done) begin
                rdt_q <= i_rd_rsp.data;
            end else if (i_wr_done) begin
                rdt_q <= '0;                                     // Writes return zero
            end
        end
    end

    assign o_req      = req_q;
    assign o_wr_start = (state == F_CAPTURE) &&  req_q.we;
    assign o_rd_start = (state == F_CAPTURE) && !req_q.we;
    assign o_wb_ack   = (state == F_ACK);
    assign o_wb_rdt   = rdt_q;

endmodule
